// ==== source/mac_config.svh ====
`ifndef MAC_CONFIG_SVH
`define MAC_CONFIG_SVH

// Word address width of the shared operand memory
`define MAC_ADDR_WIDTH 8

// Operand memory size in 32-bit words
`define MAC_MEM_DEPTH 256

// Longest job in operand words
// The job length field is sized from this
`define MAC_MAX_LEN 15

`endif

// ==== source/mac_types_pkg.sv ====
`default_nettype none

package mac_types_pkg;

    // Lane widths of the two accumulator views
    localparam int lane_width_88 = 24;
    localparam int lane_width_18 = 16;

    typedef enum logic {
        mode_88 = 1'b0,
        mode_18 = 1'b1
    } mac_mode_e;

    // Low 24 bits of an operand memory word
    typedef struct packed {
        logic signed [7:0] pixel_hi;
        logic signed [7:0] pixel_lo;
        logic [7:0]        weight;
    } mac_operand_t;

    // 8x8 view, two wide lanes
    typedef struct packed {
        logic [15:0]              pad;
        logic [lane_width_88-1:0] lane1;
        logic [lane_width_88-1:0] lane0;
    } mac_acc_wide_t;

    // Binary view, lane 2k+p holds pixel p against weight bit k
    typedef struct packed {
        logic [lane_width_18-1:0] r3;
        logic [lane_width_18-1:0] r2;
        logic [lane_width_18-1:0] r1;
        logic [lane_width_18-1:0] r0;
    } mac_acc_bin_t;

    typedef union packed {
        mac_acc_wide_t wide;
        mac_acc_bin_t  bin;
    } mac_acc_u;

endpackage

`default_nettype wire

// ==== source/bus_types_pkg.sv ====
`default_nettype none

`include "mac_config.svh"

package bus_types_pkg;

    localparam int job_len_width = $clog2(`MAC_MAX_LEN + 1);

    // Wishbone classic master request
    typedef struct packed {
        logic                       cyc;
        logic                       stb;
        logic                       we;
        logic [`MAC_ADDR_WIDTH-1:0] adr;
        logic [31:0]                dat;
    } wb_req_t;

    // Slave response
    typedef struct packed {
        logic        ack;
        logic [31:0] dat;
    } wb_rsp_t;

    // Result words land at base+len and base+len+1
    typedef struct packed {
        mac_types_pkg::mac_mode_e   mode;
        logic [`MAC_ADDR_WIDTH-1:0] base;
        logic [job_len_width-1:0]   len;
    } mac_job_t;

endpackage

`default_nettype wire

// ==== source/signed_mac_dsp.sv ====
`timescale 1ns/1ps
`default_nettype none

module signed_mac_dsp (
    input  logic                        clk,
    input  logic                        rst,
    input  logic                        en,
    input  logic                        clear,
    input  mac_types_pkg::mac_mode_e    mode,
    input  mac_types_pkg::mac_operand_t operand,
    output mac_types_pkg::mac_acc_u     acc
);

    localparam int w88 = mac_types_pkg::lane_width_88;
    localparam int w18 = mac_types_pkg::lane_width_18;

    // 8x8 products, one per pixel
    logic signed [15:0] prod_lo;
    logic signed [15:0] prod_hi;

    // Sign-extended pixels for the binary lanes
    logic signed [w18-1:0] px_lo;
    logic signed [w18-1:0] px_hi;
    logic signed [w18-1:0] term [4];

    assign prod_lo = operand.pixel_lo * $signed(operand.weight);
    assign prod_hi = operand.pixel_hi * $signed(operand.weight);

    assign px_lo = w18'(operand.pixel_lo);
    assign px_hi = w18'(operand.pixel_hi);

    // Weight bit set means -1, clear means +1
    assign term[0] = operand.weight[0] ? -px_lo : px_lo;
    assign term[1] = operand.weight[0] ? -px_hi : px_hi;
    assign term[2] = operand.weight[1] ? -px_lo : px_lo;
    assign term[3] = operand.weight[1] ? -px_hi : px_hi;

    ////////////////////////////////////////////////////////////////////////////
    // Accumulators, each lane wraps at its own width
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst || clear) begin
            acc <= '0;
        end else if (en) begin
            if (mode == mac_types_pkg::mode_88) begin
                acc.wide.lane0 <= acc.wide.lane0 + w88'(prod_lo);
                acc.wide.lane1 <= acc.wide.lane1 + w88'(prod_hi);
            end else begin
                acc.bin.r0 <= acc.bin.r0 + term[0];
                acc.bin.r1 <= acc.bin.r1 + term[1];
                acc.bin.r2 <= acc.bin.r2 + term[2];
                acc.bin.r3 <= acc.bin.r3 + term[3];
            end
        end
    end

endmodule

`default_nettype wire

// ==== source/mac_engine.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_config.svh"

module mac_engine (
    input  logic                    clk,
    input  logic                    rst,
    input  logic                    start,
    input  bus_types_pkg::mac_job_t job,
    output logic                    busy,
    output logic                    done,
    output bus_types_pkg::wb_req_t  wb_req,
    input  bus_types_pkg::wb_rsp_t  wb_rsp
);

    localparam int aw = `MAC_ADDR_WIDTH;
    localparam int lw = bus_types_pkg::job_len_width;

    typedef enum logic [2:0] {
        st_idle,
        st_clear,
        st_read,
        st_acc,
        st_wr_lo,
        st_gap,
        st_wr_hi
    } state_e;

    state_e                      state;
    bus_types_pkg::mac_job_t     job_q;
    logic [lw-1:0]               idx;
    mac_types_pkg::mac_operand_t operand_q;
    mac_types_pkg::mac_acc_u     acc;
    logic [aw-1:0]               res_adr;

    assign res_adr = job_q.base + aw'(job_q.len);
    assign busy    = (state != st_idle);

    ////////////////////////////////////////////////////////////////////////////
    // Job sequencer
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            state <= st_idle;
            done  <= 1'b0;
            idx   <= '0;
        end else begin
            done <= 1'b0;
            case (state)
                st_idle: begin
                    if (start) state <= st_clear;
                end
                st_clear: begin
                    idx   <= '0;
                    state <= (job_q.len == '0) ? st_wr_lo : st_read;
                end
                st_read: begin
                    if (wb_rsp.ack) state <= st_acc;
                end
                st_acc: begin
                    idx   <= idx + 1'b1;
                    state <= (lw'(idx + 1'b1) == job_q.len) ? st_wr_lo : st_read;
                end
                st_wr_lo: begin
                    if (wb_rsp.ack) state <= st_gap;
                end
                // stb low for one cycle between the two writes
                st_gap: state <= st_wr_hi;
                st_wr_hi: begin
                    if (wb_rsp.ack) begin
                        state <= st_idle;
                        done  <= 1'b1;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == st_idle && start) job_q <= job;
        if (state == st_read && wb_rsp.ack) begin
            operand_q <= mac_types_pkg::mac_operand_t'(wb_rsp.dat[23:0]);
        end
    end

    // cyc stays up from clear to the last write
    always_comb begin
        wb_req     = '0;
        wb_req.cyc = (state != st_idle);
        case (state)
            st_read: begin
                wb_req.stb = 1'b1;
                wb_req.adr = job_q.base + aw'(idx);
            end
            st_wr_lo: begin
                wb_req.stb = 1'b1;
                wb_req.we  = 1'b1;
                wb_req.adr = res_adr;
                wb_req.dat = acc[31:0];
            end
            st_wr_hi: begin
                wb_req.stb = 1'b1;
                wb_req.we  = 1'b1;
                wb_req.adr = res_adr + 1'b1;
                wb_req.dat = acc[63:32];
            end
            default: ;
        endcase
    end

    signed_mac_dsp u_dsp (
        .clk     (clk),
        .rst     (rst),
        .en      (state == st_acc),
        .clear   (state == st_clear),
        .mode    (job_q.mode),
        .operand (operand_q),
        .acc     (acc)
    );

endmodule

`default_nettype wire

// ==== source/wb_arbiter.sv ====
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_types_pkg::wb_req_t host_req,
    input  bus_types_pkg::wb_req_t eng_req [2],
    input  bus_types_pkg::wb_rsp_t mem_rsp,
    output bus_types_pkg::wb_rsp_t host_rsp,
    output bus_types_pkg::wb_rsp_t eng_rsp [2],
    output bus_types_pkg::wb_req_t mem_req
);

    localparam int n_masters = 3;
    localparam int iw        = $clog2(n_masters);

    // Master 0 is the host, 1 and 2 the engines
    bus_types_pkg::wb_req_t m_req [n_masters];
    logic [n_masters-1:0]   cyc_vec;
    logic [n_masters-1:0]   grant;
    logic [iw-1:0]          last_q;
    logic [iw-1:0]          pick_idx;
    logic                   pick_valid;
    logic                   owner_cyc;

    assign m_req[0] = host_req;
    assign m_req[1] = eng_req[0];
    assign m_req[2] = eng_req[1];

    always_comb begin
        for (int i = 0; i < n_masters; i++) begin
            cyc_vec[i] = m_req[i].cyc;
        end
    end

    assign owner_cyc = |(grant & cyc_vec);

    // Nearest requester after the last owner wins
    always_comb begin
        int cand;
        pick_valid = 1'b0;
        pick_idx   = last_q;
        for (int k = n_masters; k >= 1; k--) begin
            cand = (int'(last_q) + k) % n_masters;
            if (cyc_vec[cand]) begin
                pick_valid = 1'b1;
                pick_idx   = iw'(cand);
            end
        end
    end

    ////////////////////////////////////////////////////////////////////////////
    // Grant held while owner cyc is high, then one idle cycle
    ////////////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        if (rst) begin
            grant  <= '0;
            last_q <= iw'(n_masters - 1);
        end else if (grant != '0) begin
            if (!owner_cyc) grant <= '0;
        end else if (pick_valid) begin
            grant  <= n_masters'(1) << pick_idx;
            last_q <= pick_idx;
        end
    end

    always_comb begin
        mem_req = '0;
        for (int i = 0; i < n_masters; i++) begin
            if (grant[i]) mem_req = m_req[i];
        end
    end

    // Ack only to the owner
    always_comb begin
        host_rsp.ack = mem_rsp.ack & grant[0];
        host_rsp.dat = mem_rsp.dat;
        for (int e = 0; e < 2; e++) begin
            eng_rsp[e].ack = mem_rsp.ack & grant[e+1];
            eng_rsp[e].dat = mem_rsp.dat;
        end
    end

endmodule

`default_nettype wire

// ==== source/operand_ram.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_config.svh"

module operand_ram (
    input  logic                   clk,
    input  logic                   rst,
    input  bus_types_pkg::wb_req_t req,
    output bus_types_pkg::wb_rsp_t rsp
);

    logic [31:0] mem [`MAC_MEM_DEPTH];
    logic        ack_q;
    logic [31:0] rd_q;
    logic        hit;

    // New request only, so ack never repeats while stb is still held
    assign hit = req.cyc && req.stb && !ack_q;

    always_ff @(posedge clk) begin
        if (rst) ack_q <= 1'b0;
        else     ack_q <= hit;
    end

    always_ff @(posedge clk) begin
        if (hit) begin
            if (req.we) mem[req.adr] <= req.dat;
            rd_q <= mem[req.adr];
        end
    end

    assign rsp.ack = ack_q;
    assign rsp.dat = rd_q;

endmodule

`default_nettype wire

// ==== source/mac_cluster_top.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cluster_top (
    input  logic                    clk,
    input  logic                    rst,
    input  bus_types_pkg::wb_req_t  host_req,
    output bus_types_pkg::wb_rsp_t  host_rsp,
    input  logic [1:0]              start,
    input  bus_types_pkg::mac_job_t job [2],
    output logic [1:0]              busy,
    output logic [1:0]              done
);

    bus_types_pkg::wb_req_t eng_req [2];
    bus_types_pkg::wb_rsp_t eng_rsp [2];
    bus_types_pkg::wb_req_t mem_req;
    bus_types_pkg::wb_rsp_t mem_rsp;

    // Two peer engines
    for (genvar e = 0; e < 2; e++) begin : g_eng
        mac_engine u_engine (
            .clk    (clk),
            .rst    (rst),
            .start  (start[e]),
            .job    (job[e]),
            .busy   (busy[e]),
            .done   (done[e]),
            .wb_req (eng_req[e]),
            .wb_rsp (eng_rsp[e])
        );
    end

    wb_arbiter u_arbiter (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .eng_req  (eng_req),
        .mem_rsp  (mem_rsp),
        .host_rsp (host_rsp),
        .eng_rsp  (eng_rsp),
        .mem_req  (mem_req)
    );

    operand_ram u_ram (
        .clk (clk),
        .rst (rst),
        .req (mem_req),
        .rsp (mem_rsp)
    );

endmodule

`default_nettype wire

// ==== verif/mac_cluster_properties.sv ====
`timescale 1ns/1ps
`default_nettype none

module mac_cluster_properties (
    input logic                   clk,
    input logic                   rst,
    input logic [2:0]             grant,
    input logic [2:0]             cyc_vec,
    input bus_types_pkg::wb_req_t mem_req,
    input bus_types_pkg::wb_rsp_t mem_rsp
);

    // At most one owner at a time
    grant_onehot: assert property (@(posedge clk) disable iff (rst) $onehot0(grant))
        else $error("grant not one-hot or zero: %b", grant);

    grant_held: assert property (@(posedge clk) disable iff (rst)
        (|(grant & cyc_vec)) |=> $stable(grant))
        else $error("grant moved while its owner still held cyc");

    // The RAM answers only a live strobe
    ack_needs_stb: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ack |-> (mem_req.cyc && mem_req.stb))
        else $error("ack seen without cyc and stb on the RAM request");

    ack_single: assert property (@(posedge clk) disable iff (rst)
        mem_rsp.ack |=> !mem_rsp.ack)
        else $error("ack held high for two cycles");

endmodule

bind wb_arbiter mac_cluster_properties u_props (
    .clk     (clk),
    .rst     (rst),
    .grant   (grant),
    .cyc_vec (cyc_vec),
    .mem_req (mem_req),
    .mem_rsp (mem_rsp)
);

`default_nettype wire

// ==== verif/mac_cluster_tb.sv ====
`timescale 1ns/1ps
`default_nettype none

`include "mac_config.svh"

module mac_cluster_tb;

    localparam int aw        = `MAC_ADDR_WIDTH;
    localparam int lw        = bus_types_pkg::job_len_width;
    localparam int max_tests = 32;
    localparam int timeout   = 2000;

    logic                    clk;
    logic                    rst;
    bus_types_pkg::wb_req_t  host_req;
    bus_types_pkg::wb_rsp_t  host_rsp;
    logic [1:0]              start;
    bus_types_pkg::mac_job_t job [2];
    logic [1:0]              busy;
    logic [1:0]              done;

    // Test table from the stimulus file
    logic [8*16-1:0] t_name [max_tests];
    int              t_eng [max_tests];
    int              t_mode [max_tests];
    int              t_len [max_tests];
    logic [aw-1:0]   t_base [max_tests];
    logic [31:0]     t_word [max_tests][4];
    logic [31:0]     t_exp_hi [max_tests];
    logic [31:0]     t_exp_lo [max_tests];
    int              n_tests;

    int pass_cnt;
    int fail_cnt;
    int done_cnt [2] = '{0, 0};

    mac_cluster_top uut (
        .clk      (clk),
        .rst      (rst),
        .host_req (host_req),
        .host_rsp (host_rsp),
        .start    (start),
        .job      (job),
        .busy     (busy),
        .done     (done)
    );

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    // Count one-cycle done pulses on the falling edge
    always @(negedge clk) begin
        for (int e = 0; e < 2; e++) begin
            if (done[e]) done_cnt[e] = done_cnt[e] + 1;
        end
    end

    function automatic logic [31:0] fill_word(input logic [aw-1:0] adr);
        return {4{adr}} ^ 32'h5a3c_c3a5;
    endfunction

    task automatic next_cycle();
        @(posedge clk);
        #5;
    endtask

    // One Wishbone classic transfer followed by an idle cycle
    task automatic host_xfer(input logic we, input logic [aw-1:0] adr,
                             input logic [31:0] wdat, output logic [31:0] rdat);
        int   n;
        logic ok;
        n            = 0;
        ok           = 1'b0;
        host_req.cyc = 1'b1;
        host_req.stb = 1'b1;
        host_req.we  = we;
        host_req.adr = adr;
        host_req.dat = wdat;
        while (!ok && n < timeout) begin
            next_cycle();
            ok = host_rsp.ack;
            n++;
        end
        rdat = host_rsp.dat;
        // Request stays up until the edge that closes the ack cycle
        next_cycle();
        host_req = '0;
        if (!ok) begin
            $display("timed out waiting for host ack at address %h", adr);
            fail_cnt++;
        end
        next_cycle();
    endtask

    task automatic load_stim();
        int              fd;
        int              cnt;
        string           line;
        logic [8*16-1:0] name;
        int              eng;
        int              mode;
        int              len;
        logic [31:0]     base;
        logic [31:0]     w [4];
        logic [31:0]     hi;
        logic [31:0]     lo;
        n_tests = 0;
        fd = $fopen("verif/mac_cluster_stim.txt", "r");
        if (fd == 0) begin
            $display("could not open the stimulus file");
            fail_cnt++;
            return;
        end
        while (!$feof(fd) && n_tests < max_tests) begin
            cnt = $fgets(line, fd);
            if (cnt > 1 && line[0] != "#") begin
                cnt = $sscanf(line, "%s %d %d %d %h %h %h %h %h %h %h", name, eng, mode,
                              len, base, w[0], w[1], w[2], w[3], hi, lo);
                if (cnt != 11) begin
                    $display("malformed stimulus line: %0s", line);
                    fail_cnt++;
                end else begin
                    t_name[n_tests]   = name;
                    t_eng[n_tests]    = eng;
                    t_mode[n_tests]   = mode;
                    t_len[n_tests]    = len;
                    t_base[n_tests]   = base[aw-1:0];
                    t_exp_hi[n_tests] = hi;
                    t_exp_lo[n_tests] = lo;
                    for (int k = 0; k < 4; k++) t_word[n_tests][k] = w[k];
                    n_tests++;
                end
            end
        end
        $fclose(fd);
    endtask

    ////////////////////////////////////////////////////////////////////////////
    // Run one job or two jobs started on the same cycle
    ////////////////////////////////////////////////////////////////////////////

    task automatic run_group(input int first, input int count);
        int            eng_of [2];
        int            want [2];
        int            t;
        int            n;
        logic          good [2];
        logic          scratch_ok;
        logic [31:0]   rd;
        logic [aw-1:0] res;
        logic [aw-1:0] scratch;
        if (count == 2 || t_eng[first] == 2) eng_of[0] = int'($urandom % 2);
        else eng_of[0] = t_eng[first];
        eng_of[1] = 1 - eng_of[0];

        // Load operands and a known pattern into the result words
        for (int j = 0; j < count; j++) begin
            t     = first + j;
            good[j] = 1'b1;
            for (int i = 0; i < t_len[t]; i++) begin
                host_xfer(1'b1, t_base[t] + aw'(i), t_word[t][i < 4 ? i : 3], rd);
            end
            res = t_base[t] + aw'(t_len[t]);
            host_xfer(1'b1, res, fill_word(res), rd);
            host_xfer(1'b1, res + 1'b1, fill_word(res + 1'b1), rd);
        end

        for (int j = 0; j < count; j++) begin
            t                    = first + j;
            job[eng_of[j]].mode  = mac_types_pkg::mac_mode_e'(t_mode[t][0]);
            job[eng_of[j]].base  = t_base[t];
            job[eng_of[j]].len   = lw'(t_len[t]);
            want[j]              = done_cnt[eng_of[j]] + 1;
            start[eng_of[j]]     = 1'b1;
        end
        next_cycle();
        start = 2'b00;
        for (int j = 0; j < count; j++) begin
            if (!busy[eng_of[j]]) begin
                $display("engine %0d did not go busy after start", eng_of[j]);
                good[j] = 1'b0;
            end
        end

        // Host traffic while the engines own parts of the bus
        scratch    = aw'(224 + first);
        scratch_ok = 1'b1;
        host_xfer(1'b1, scratch, fill_word(scratch), rd);
        host_xfer(1'b0, scratch, '0, rd);
        if (rd !== fill_word(scratch)) begin
            $display("[ERROR] host_rw_%0s expected %h actual %h", t_name[first],
                     fill_word(scratch), rd);
            scratch_ok = 1'b0;
        end
        if (scratch_ok) begin
            $display("PASS host_rw_%0s", t_name[first]);
            pass_cnt++;
        end else begin
            $display("FAIL host_rw_%0s", t_name[first]);
            fail_cnt++;
        end

        for (int j = 0; j < count; j++) begin
            n = 0;
            while (done_cnt[eng_of[j]] < want[j] && n < timeout) begin
                next_cycle();
                n++;
            end
            if (done_cnt[eng_of[j]] < want[j]) begin
                $display("timed out waiting for engine %0d done", eng_of[j]);
                good[j] = 1'b0;
            end
        end

        // Low word at base+len and the high word right after it
        for (int j = 0; j < count; j++) begin
            t   = first + j;
            res = t_base[t] + aw'(t_len[t]);
            host_xfer(1'b0, res, '0, rd);
            if (rd !== t_exp_lo[t]) begin
                $display("[ERROR] %0s low word expected %h actual %h", t_name[t],
                         t_exp_lo[t], rd);
                good[j] = 1'b0;
            end
            host_xfer(1'b0, res + 1'b1, '0, rd);
            if (rd !== t_exp_hi[t]) begin
                $display("[ERROR] %0s high word expected %h actual %h", t_name[t],
                         t_exp_hi[t], rd);
                good[j] = 1'b0;
            end
            if (good[j]) begin
                $display("PASS %0s on engine %0d", t_name[t], eng_of[j]);
                pass_cnt++;
            end else begin
                $display("FAIL %0s on engine %0d", t_name[t], eng_of[j]);
                fail_cnt++;
            end
        end
    endtask

    initial begin
        int i;
        rst      = 1'b1;
        host_req = '0;
        start    = 2'b00;
        job[0]   = '0;
        job[1]   = '0;
        pass_cnt = 0;
        fail_cnt = 0;
        void'($urandom(38252));
        load_stim();
        repeat (10) @(posedge clk);
        #5;
        rst = 1'b0;
        next_cycle();
        if (busy !== 2'b00 || done !== 2'b00) begin
            $display("busy or done not low after reset");
            fail_cnt++;
        end

        i = 0;
        while (i < n_tests) begin
            if (t_eng[i] == 3 && i + 1 < n_tests) begin
                run_group(i, 2);
                i += 2;
            end else begin
                run_group(i, 1);
                i += 1;
            end
        end

        $display("Summary: %0d passed, %0d failed", pass_cnt, fail_cnt);
        if (fail_cnt == 0 && n_tests > 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== verif/mac_cluster_stim.txt ====
# name eng mode len base w0 w1 w2 w3 exp_hi exp_lo (base and words in hex)
# eng 2 = random engine, 3 = two lines started together; words past w3 repeat w3
mac88_signed    0 0 3  00 000afdfb 009c0703 007f8080 00000000 0000ffbf 22004024
bin_weights     1 1 4  10 0005ec00 00f91e01 0064ff02 008040f7 001affcb 00f0ff8d
pair_a_88       3 0 2  20 00020304 00fffe09 00000000 00000000 0000ffff fffffffa
pair_b_bin      3 1 3  30 00010200 00010200 00030401 00000000 00050008 ffff0000
second_job_e0   0 0 1  40 00010101 00000000 00000000 00000000 00000000 01000001
second_job_e1   1 0 2  44 00fe0203 00010101 00000000 00000000 0000ffff fb000007
lane_wrap       2 1 15 50 007f8002 007f8002 007f8002 007f8002 f88f0780 0771f880

// ==== build.f ====
+incdir+source
source/mac_types_pkg.sv
source/bus_types_pkg.sv
source/signed_mac_dsp.sv
source/mac_engine.sv
source/wb_arbiter.sv
source/operand_ram.sv
source/mac_cluster_top.sv
verif/mac_cluster_properties.sv
verif/mac_cluster_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the testbench with Verilator from the project root
cd "$(dirname "$0")" || exit 1

log=sim.log
rm -rf obj_dir "$log"

verilator --binary --timing --assert -Wno-fatal \
    -f build.f --top-module mac_cluster_tb -o mac_cluster_sim
if [ $? -ne 0 ]; then
    echo "Verilator build step failed"
    exit 1
fi

./obj_dir/mac_cluster_sim > "$log" 2>&1
status=$?
cat "$log"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Verification failed" "$log"; then
    exit 1
fi
exit 0
